//--- src/idct_pkg.sv
/*
  Shared widths, SRAM and buffer port structs, and the IDCT cosine table.
  The table is indexed k*8+c and scaled by 4096, so one pass scales by 2^12.
*/

`default_nettype none

package idct_pkg;

	localparam int addr_w = 18;
	localparam int coef_w = 16;
	localparam int acc_w = 32;
	localparam int blk_n = 8;
	localparam int blk_words = 64;
	localparam int buf_addr_w = 6;

	// one SRAM access, we_n low for a write
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [coef_w-1:0] wdata;
		logic              we_n;
	} sram_req_t;

	// stage buffer read port
	// request carries addr, response echoes it with data one cycle later
	typedef struct packed {
		logic [buf_addr_w-1:0] addr;
		logic [acc_w-1:0]      data;
	} buf_rd_t;

	// 4096 * a(k) * cos((2c+1)k*pi/16)
	localparam logic signed [coef_w-1:0] cos_table [blk_words] = '{
		// k = 0
		16'sd1448,  16'sd1448,  16'sd1448,  16'sd1448,
		16'sd1448,  16'sd1448,  16'sd1448,  16'sd1448,
		// k = 1
		16'sd2009,  16'sd1703,  16'sd1138,  16'sd400,
		-16'sd400,  -16'sd1138, -16'sd1703, -16'sd2009,
		// k = 2
		16'sd1892,  16'sd784,   -16'sd784,  -16'sd1892,
		-16'sd1892, -16'sd784,  16'sd784,   16'sd1892,
		// k = 3
		16'sd1703,  -16'sd400,  -16'sd2009, -16'sd1138,
		16'sd1138,  16'sd2009,  16'sd400,   -16'sd1703,
		// k = 4
		16'sd1448,  -16'sd1448, -16'sd1448, 16'sd1448,
		16'sd1448,  -16'sd1448, -16'sd1448, 16'sd1448,
		// k = 5
		16'sd1138,  -16'sd2009, 16'sd400,   16'sd1703,
		-16'sd1703, -16'sd400,  16'sd2009,  -16'sd1138,
		// k = 6
		16'sd784,   -16'sd1892, 16'sd1892,  -16'sd784,
		-16'sd784,  16'sd1892,  -16'sd1892, 16'sd784,
		// k = 7
		16'sd400,   -16'sd1138, 16'sd1703,  -16'sd2009,
		16'sd2009,  -16'sd1703, 16'sd1138,  -16'sd400
	};

endpackage

`default_nettype wire

//--- src/block_fetch.sv
/*
  Reads the 64 coefficients of one block, one SRAM word per cycle.
  Read data is captured on the second edge after the edge that drives the address.
  go_i is ignored while a fetch is running.
*/

`timescale 1ns/1ps
`default_nettype none

module block_fetch import idct_pkg::*; #(
	parameter int blocks_per_row = 2,
	parameter int block_rows = 2,
	parameter int coef_base = 0,
	localparam int row_w = (block_rows > 1) ? $clog2(block_rows) : 1,
	localparam int col_w = (blocks_per_row > 1) ? $clog2(blocks_per_row) : 1
) (
	input  logic             Clock,
	input  logic             Resetn,
	input  logic             go_i,
	input  logic [row_w-1:0] blk_row_i,
	input  logic [col_w-1:0] blk_col_i,
	input  logic [15:0]      sram_rdata_i,
	output sram_req_t        sram_o,
	input  buf_rd_t          rd_i,
	output buf_rd_t          rd_o,
	output logic             done_o
);

	localparam int row_pitch = blocks_per_row * blk_n;

	logic issuing;
	logic [buf_addr_w-1:0] cnt;
	logic [addr_w-1:0] row_base;
	logic [addr_w-1:0] req_addr;
	// reads in flight
	logic s1_v, s2_v;
	logic [buf_addr_w-1:0] s1_idx, s2_idx;
	logic [acc_w-1:0] mem [blk_words];

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			issuing <= 1'b0;
			cnt <= '0;
			row_base <= '0;
			req_addr <= '0;
			s1_v <= 1'b0;
			s2_v <= 1'b0;
			s1_idx <= '0;
			s2_idx <= '0;
			done_o <= 1'b0;
		end else begin
			s1_v <= 1'b0;
			if (issuing) begin
				req_addr <= row_base + addr_w'(cnt[2:0]);
				s1_v <= 1'b1;
				s1_idx <= cnt;
				cnt <= cnt + 1'b1;
				// end of a block row
				if (cnt[2:0] == 3'd7)
					row_base <= row_base + addr_w'(row_pitch);
				if (cnt == buf_addr_w'(blk_words - 1))
					issuing <= 1'b0;
			end else if (go_i) begin
				issuing <= 1'b1;
				cnt <= '0;
				row_base <= addr_w'(coef_base)
					+ addr_w'(blk_row_i) * addr_w'(blk_n * row_pitch)
					+ addr_w'(blk_col_i) * addr_w'(blk_n);
			end
			s2_v <= s1_v;
			s2_idx <= s1_idx;
			done_o <= s2_v && (s2_idx == buf_addr_w'(blk_words - 1));
		end
	end

	// sign-extended coefficient store, row*8+col
	always_ff @(posedge Clock) begin
		if (s2_v)
			mem[s2_idx] <= acc_w'($signed(sram_rdata_i));
		rd_o.addr <= rd_i.addr;
		rd_o.data <= mem[rd_i.addr];
	end

	assign sram_o = '{addr: req_addr, wdata: '0, we_n: 1'b1};

endmodule

`default_nettype wire

//--- src/idct_pass.sv
/*
  One matrix pass: Y[r][c] = (sum_k X[k][r] * table[k][c]) >>> out_shift.
  Column r of the source is loaded into a shift register, then two
  multipliers finish one output every four cycles. Results land at r*8+c.
  Products and sums are kept to 32 bits.
*/

`timescale 1ns/1ps
`default_nettype none

module idct_pass import idct_pkg::*; #(
	parameter int out_shift = 8
) (
	input  logic    Clock,
	input  logic    Resetn,
	input  logic    go_i,
	output buf_rd_t src_o,
	input  buf_rd_t src_i,
	input  buf_rd_t rd_i,
	output buf_rd_t rd_o,
	output logic    done_o
);

	typedef enum logic [1:0] {idle_s, load_s, calc_s} state_t;

	state_t state;
	logic [2:0] row, col;
	logic [1:0] step;
	logic [3:0] ld_cnt;
	logic signed [acc_w-1:0] rowbuf [blk_n];
	logic signed [acc_w-1:0] acc, acc_sum;
	logic signed [acc_w-1:0] prod_a, prod_b;
	logic load_cap, wr_en;
	logic [acc_w-1:0] mem [blk_words];

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= idle_s;
			row <= '0;
			col <= '0;
			step <= '0;
			ld_cnt <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				idle_s: begin
					if (go_i) begin
						row <= '0;
						ld_cnt <= '0;
						state <= load_s;
					end
				end
				load_s: begin
					ld_cnt <= ld_cnt + 1'b1;
					if (ld_cnt == 4'd8) begin
						col <= '0;
						step <= '0;
						state <= calc_s;
					end
				end
				calc_s: begin
					step <= step + 1'b1;
					if (step == 2'd3) begin
						col <= col + 1'b1;
						if (col == 3'd7) begin
							if (row == 3'd7) begin
								done_o <= 1'b1;
								state <= idle_s;
							end else begin
								row <= row + 1'b1;
								ld_cnt <= '0;
								state <= load_s;
							end
						end
					end
				end
				default: state <= idle_s;
			endcase
		end
	end

	// source word k*8+r, data back one cycle later
	assign src_o = '{addr: {ld_cnt[2:0], row}, data: '0};
	assign load_cap = (state == load_s) && (ld_cnt != 4'd0);

	// rowbuf[0] and rowbuf[1] hold terms 2*step and 2*step+1
	assign prod_a = rowbuf[0] * cos_table[{step, 1'b0, col}];
	assign prod_b = rowbuf[1] * cos_table[{step, 1'b1, col}];
	assign acc_sum = ((step == 2'd0) ? '0 : acc) + prod_a + prod_b;
	assign wr_en = (state == calc_s) && (step == 2'd3);

	always_ff @(posedge Clock) begin
		if (load_cap) begin
			for (int i = 0; i < blk_n - 1; i++)
				rowbuf[i] <= rowbuf[i + 1];
			rowbuf[blk_n - 1] <= $signed(src_i.data);
		end else if (state == calc_s) begin
			// rotate by two, back in place after four steps
			for (int i = 0; i < blk_n; i++)
				rowbuf[i] <= rowbuf[(i + 2) % blk_n];
		end
		acc <= acc_sum;
	end

	always_ff @(posedge Clock) begin
		if (wr_en)
			mem[{row, col}] <= acc_sum >>> out_shift;
		rd_o.addr <= rd_i.addr;
		rd_o.data <= mem[rd_i.addr];
	end

endmodule

`default_nettype wire

//--- src/pixel_writer.sv
/*
  Clips pass-2 results to 0..255 and writes pixel pairs, even column
  in the high byte. One read per cycle, so a write goes out every other
  cycle; active_o spans the whole write phase.
*/

`timescale 1ns/1ps
`default_nettype none

module pixel_writer import idct_pkg::*; #(
	parameter int blocks_per_row = 2,
	parameter int block_rows = 2,
	parameter int pixel_base = 4096,
	localparam int row_w = (block_rows > 1) ? $clog2(block_rows) : 1,
	localparam int col_w = (blocks_per_row > 1) ? $clog2(blocks_per_row) : 1
) (
	input  logic             Clock,
	input  logic             Resetn,
	input  logic             go_i,
	input  logic [row_w-1:0] blk_row_i,
	input  logic [col_w-1:0] blk_col_i,
	output buf_rd_t          src_o,
	input  buf_rd_t          src_i,
	output sram_req_t        sram_o,
	output logic             active_o,
	output logic             done_o
);

	localparam int pix_pitch = blocks_per_row * blk_n / 2;

	logic running, rv, last_q, we_n;
	logic [buf_addr_w-1:0] rd_idx;
	logic [addr_w-1:0] blk_base, wr_addr;
	logic [7:0] hi_byte;
	logic [15:0] wr_data;

	function automatic logic [7:0] clip8(input logic signed [acc_w-1:0] v);
		if (v < 0)
			return 8'd0;
		else if (v > 255)
			return 8'd255;
		else
			return v[7:0];
	endfunction

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			running <= 1'b0;
			active_o <= 1'b0;
			rd_idx <= '0;
			rv <= 1'b0;
			last_q <= 1'b0;
			we_n <= 1'b1;
			done_o <= 1'b0;
		end else begin
			if (go_i && !active_o) begin
				active_o <= 1'b1;
				running <= 1'b1;
				rd_idx <= '0;
			end else if (running) begin
				rd_idx <= rd_idx + 1'b1;
				if (rd_idx == buf_addr_w'(blk_words - 1))
					running <= 1'b0;
			end
			rv <= running;
			// odd column completes a pair
			we_n <= !(rv && src_i.addr[0]);
			last_q <= rv && (src_i.addr == buf_addr_w'(blk_words - 1));
			done_o <= last_q;
			if (last_q)
				active_o <= 1'b0;
		end
	end

	always_ff @(posedge Clock) begin
		if (go_i && !active_o)
			blk_base <= addr_w'(pixel_base)
				+ addr_w'(blk_row_i) * addr_w'(blk_n * pix_pitch)
				+ addr_w'(blk_col_i) * addr_w'(blk_n / 2);
		if (rv && !src_i.addr[0])
			hi_byte <= clip8($signed(src_i.data));
		wr_addr <= blk_base + addr_w'(src_i.addr[5:3]) * addr_w'(pix_pitch)
			+ addr_w'(src_i.addr[2:1]);
		wr_data <= {hi_byte, clip8($signed(src_i.data))};
	end

	assign src_o = '{addr: rd_idx, data: '0};
	assign sram_o = '{addr: wr_addr, wdata: wr_data, we_n: we_n};

endmodule

`default_nettype wire

//--- src/idct_top.sv
/*
  Block IDCT over a blocks_per_row x block_rows grid in one SRAM plane.
  Blocks run one at a time; start_i is ignored while busy_o is high.
  Coefficient and pixel regions must not overlap. Large coefficients
  can overflow the 32-bit accumulators; there is no saturation before the clip.
*/

`timescale 1ns/1ps
`default_nettype none

module idct_top import idct_pkg::*; #(
	parameter int blocks_per_row = 2,
	parameter int block_rows = 2,
	parameter int coef_base = 0,
	parameter int pixel_base = 4096,
	localparam int row_w = (block_rows > 1) ? $clog2(block_rows) : 1,
	localparam int col_w = (blocks_per_row > 1) ? $clog2(blocks_per_row) : 1
) (
	input  logic        Clock,
	input  logic        Resetn,
	input  logic        start_i,
	input  logic [15:0] sram_rdata_i,
	output sram_req_t   sram_o,
	output logic        busy_o,
	output logic        done_o
);

	logic [row_w-1:0] blk_row;
	logic [col_w-1:0] blk_col;
	logic go_fetch;
	logic fetch_done, pass1_done, pass2_done, write_done;
	logic writer_active;
	sram_req_t fetch_req, writer_req;
	buf_rd_t fetch_rd_req, fetch_rd_rsp;
	buf_rd_t pass1_rd_req, pass1_rd_rsp;
	buf_rd_t pass2_rd_req, pass2_rd_rsp;

	// raster block walk, next block only after the previous write-back
	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			busy_o <= 1'b0;
			done_o <= 1'b0;
			go_fetch <= 1'b0;
			blk_row <= '0;
			blk_col <= '0;
		end else begin
			go_fetch <= 1'b0;
			done_o <= 1'b0;
			if (!busy_o) begin
				if (start_i) begin
					busy_o <= 1'b1;
					blk_row <= '0;
					blk_col <= '0;
					go_fetch <= 1'b1;
				end
			end else if (write_done) begin
				if (blk_col == col_w'(blocks_per_row - 1)) begin
					blk_col <= '0;
					if (blk_row == row_w'(block_rows - 1)) begin
						busy_o <= 1'b0;
						done_o <= 1'b1;
					end else begin
						blk_row <= blk_row + 1'b1;
						go_fetch <= 1'b1;
					end
				end else begin
					blk_col <= blk_col + 1'b1;
					go_fetch <= 1'b1;
				end
			end
		end
	end

	// writer owns the port only during its write phase
	assign sram_o = writer_active ? writer_req : fetch_req;

	block_fetch #(
		.blocks_per_row(blocks_per_row),
		.block_rows(block_rows),
		.coef_base(coef_base)
	) u_fetch (
		.Clock(Clock), .Resetn(Resetn), .go_i(go_fetch),
		.blk_row_i(blk_row), .blk_col_i(blk_col),
		.sram_rdata_i(sram_rdata_i), .sram_o(fetch_req),
		.rd_i(fetch_rd_req), .rd_o(fetch_rd_rsp), .done_o(fetch_done)
	);

	idct_pass #(.out_shift(8)) u_pass_rows (
		.Clock(Clock), .Resetn(Resetn), .go_i(fetch_done),
		.src_o(fetch_rd_req), .src_i(fetch_rd_rsp),
		.rd_i(pass1_rd_req), .rd_o(pass1_rd_rsp), .done_o(pass1_done)
	);

	idct_pass #(.out_shift(16)) u_pass_cols (
		.Clock(Clock), .Resetn(Resetn), .go_i(pass1_done),
		.src_o(pass1_rd_req), .src_i(pass1_rd_rsp),
		.rd_i(pass2_rd_req), .rd_o(pass2_rd_rsp), .done_o(pass2_done)
	);

	pixel_writer #(
		.blocks_per_row(blocks_per_row),
		.block_rows(block_rows),
		.pixel_base(pixel_base)
	) u_writer (
		.Clock(Clock), .Resetn(Resetn), .go_i(pass2_done),
		.blk_row_i(blk_row), .blk_col_i(blk_col),
		.src_o(pass2_rd_req), .src_i(pass2_rd_rsp),
		.sram_o(writer_req), .active_o(writer_active), .done_o(write_done)
	);

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
/*
  Free-running testbench clock, low at time zero.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int period_ns = 20
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(period_ns / 2) clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

//--- verif/idct_props.sv
/*
  Protocol properties for idct_top, attached by bind.
  fail_count holds the number of failed properties.
*/

`timescale 1ns/1ps
`default_nettype none

module idct_props import idct_pkg::*; #(
	parameter int blocks_per_row = 2,
	parameter int block_rows = 2,
	parameter int pixel_base = 4096
) (
	input logic      Clock,
	input logic      Resetn,
	input logic      busy_i,
	input logic      done_i,
	input sram_req_t sram_i
);

	localparam int pixel_words = block_rows * blk_n * blocks_per_row * blk_n / 2;

	int fail_count = 0;

	// writes only happen inside a run
	a_no_idle_write: assert property (@(posedge Clock) disable iff (!Resetn)
		!busy_i |-> sram_i.we_n)
	else begin
		fail_count++;
		$error("SRAM write while busy_o is low");
	end

	a_done_single: assert property (@(posedge Clock) disable iff (!Resetn)
		done_i |=> !done_i)
	else begin
		fail_count++;
		$error("done_o held for more than one cycle");
	end

	a_done_on_fall: assert property (@(posedge Clock) disable iff (!Resetn)
		done_i |-> $fell(busy_i))
	else begin
		fail_count++;
		$error("done_o without busy_o falling");
	end

	a_fall_has_done: assert property (@(posedge Clock) disable iff (!Resetn)
		$fell(busy_i) |-> done_i)
	else begin
		fail_count++;
		$error("busy_o fell without done_o");
	end

	a_write_in_region: assert property (@(posedge Clock) disable iff (!Resetn)
		!sram_i.we_n |-> (sram_i.addr >= addr_w'(pixel_base)
			&& sram_i.addr < addr_w'(pixel_base + pixel_words)))
	else begin
		fail_count++;
		$error("SRAM write outside the pixel region");
	end

endmodule

bind idct_top idct_props #(
	.blocks_per_row(blocks_per_row),
	.block_rows(block_rows),
	.pixel_base(pixel_base)
) u_props (
	.Clock(Clock),
	.Resetn(Resetn),
	.busy_i(busy_o),
	.done_i(done_o),
	.sram_i(sram_o)
);

`default_nettype wire

//--- verif/idct_tb.sv
/*
  Testbench for idct_top on a 2x2 block grid in a behavioral SRAM.
  The SRAM model samples requests on the falling edge and returns read data
  so that the DUT samples it two edges after the address edge.
  Coefficients come from an LCG with a fixed seed.
*/

`timescale 1ns/1ps
`default_nettype none

module idct_tb import idct_pkg::*; ();

	localparam int blocks_per_row = 2;
	localparam int block_rows = 2;
	localparam int coef_base = 0;
	localparam int pixel_base = 4096;
	localparam int frame_w = blocks_per_row * blk_n;
	localparam int frame_h = block_rows * blk_n;
	localparam int pix_pitch = frame_w / 2;
	localparam int pixel_words = frame_h * pix_pitch;
	localparam int n_blocks = blocks_per_row * block_rows;
	localparam int n_tests = 6;
	localparam int clk_period_ns = 20;
	localparam int run_limit = n_blocks * 2000;
	localparam int watchdog_cycles = n_tests * n_blocks * 2000;
	localparam int sram_words = 1 << addr_w;

	logic Clock;
	logic Resetn;
	logic start;
	logic busy;
	logic done;
	logic [15:0] rdata = '0;
	logic [addr_w-1:0] sram_addr_q = '0;
	sram_req_t sram_req;

	logic [15:0] sram [sram_words];
	logic [15:0] exp_pix [pixel_words];
	int coef [frame_w * frame_h];
	logic [31:0] rng_state = 32'hc03b_1fd5;
	int errors = 0;
	int checks = 0;
	int failed_tests = 0;
	int test_num = 0;
	int faults_at_start = 0;
	int write_count = 0;
	int done_count = 0;

	tb_clock #(.period_ns(clk_period_ns)) u_clock (.clk_o(Clock));

	idct_top #(
		.blocks_per_row(blocks_per_row),
		.block_rows(block_rows),
		.coef_base(coef_base),
		.pixel_base(pixel_base)
	) i_dut (
		.Clock(Clock),
		.Resetn(Resetn),
		.start_i(start),
		.sram_rdata_i(rdata),
		.sram_o(sram_req),
		.busy_o(busy),
		.done_o(done)
	);

	// behavioral SRAM with the address held one cycle before the read
	always @(negedge Clock) begin
		rdata <= sram[sram_addr_q];
		sram_addr_q <= sram_req.addr;
		if (!sram_req.we_n) begin
			sram[sram_req.addr] = sram_req.wdata;
			write_count = write_count + 1;
			checks = checks + 1;
			assert (sram_req.addr >= pixel_base && sram_req.addr < pixel_base + pixel_words)
			else begin
				$display("[ERROR] %0t: write to %h outside the pixel region",
					$time, sram_req.addr);
				errors = errors + 1;
			end
		end
	end

	always @(negedge Clock) begin
		if (done)
			done_count = done_count + 1;
	end

	initial begin : watchdog
		#(watchdog_cycles * clk_period_ns);
		$display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// uniform in lo..hi from the upper LCG bits
	function automatic int rand_range(input int lo, input int hi);
		rng_state = lcg_next(rng_state);
		return lo + int'(rng_state[31:16] % (hi - lo + 1));
	endfunction

	function automatic logic [15:0] fill_word(input int a);
		return 16'(a) ^ 16'(a >> 2) ^ 16'h5a3c;
	endfunction

	function automatic logic [7:0] clip_byte(input int v);
		if (v < 0)
			return 8'd0;
		if (v > 255)
			return 8'd255;
		return v[7:0];
	endfunction

	function automatic int fault_total();
		return errors + i_dut.u_props.fail_count;
	endfunction

	// Y[r][c] = (sum_k X[k][r] * table[k][c]) >>> shift with 32-bit wrap
	task automatic matrix_pass(input int src [64], output int dst [64], input int shift);
		int r, c, k, sum;
		for (r = 0; r < blk_n; r++)
			for (c = 0; c < blk_n; c++) begin
				sum = 0;
				for (k = 0; k < blk_n; k++)
					sum += src[k * blk_n + r] * int'(cos_table[k * blk_n + c]);
				dst[r * blk_n + c] = sum >>> shift;
			end
	endtask

	// expected pixel words with the even column in the high byte
	task automatic build_expected();
		int x [64];
		int y1 [64];
		int y2 [64];
		int br, bc, r, c, word;
		for (br = 0; br < block_rows; br++)
			for (bc = 0; bc < blocks_per_row; bc++) begin
				for (r = 0; r < blk_n; r++)
					for (c = 0; c < blk_n; c++)
						x[r * blk_n + c] = coef[(br * blk_n + r) * frame_w + bc * blk_n + c];
				matrix_pass(x, y1, 8);
				matrix_pass(y1, y2, 16);
				for (r = 0; r < blk_n; r++)
					for (c = 0; c < blk_n; c += 2) begin
						word = (br * blk_n + r) * pix_pitch + bc * 4 + c / 2;
						exp_pix[word] = {clip_byte(y2[r * blk_n + c]),
							clip_byte(y2[r * blk_n + c + 1])};
					end
			end
	endtask

	// kind 0 zero, 1 random DC only, 2 small random, 3 large DC alternating sign
	task automatic make_frame(input int kind);
		int i, fr, fc, b;
		bit is_dc;
		for (i = 0; i < frame_w * frame_h; i++) begin
			fr = i / frame_w;
			fc = i % frame_w;
			b = (fr / blk_n) * blocks_per_row + fc / blk_n;
			is_dc = (fr % blk_n == 0) && (fc % blk_n == 0);
			coef[i] = 0;
			if (kind == 2)
				coef[i] = is_dc ? rand_range(0, 1200) : rand_range(-48, 48);
			else if (kind == 1 && is_dc)
				coef[i] = rand_range(-200, 1400);
			else if (kind == 3 && is_dc)
				coef[i] = (b % 2 == 0) ? rand_range(16000, 32767) : rand_range(-32768, -16000);
		end
	endtask

	// coefficients in and fill pattern over the pixel region
	task automatic load_frame();
		int i;
		for (i = 0; i < frame_w * frame_h; i++)
			sram[coef_base + i] = 16'(coef[i]);
		for (i = 0; i < pixel_words; i++)
			sram[pixel_base + i] = fill_word(pixel_base + i);
		build_expected();
	endtask

	task automatic run_frame(input bit restart);
		int n, writes0, dones0;
		bit seen;
		writes0 = write_count;
		dones0 = done_count;
		start = 1'b1;
		@(negedge Clock);
		start = 1'b0;
		n = 0;
		seen = 1'b0;
		while (!seen && n < run_limit) begin
			start = 1'b0;
			if (restart && (n == 100 || n == 1500)) begin
				checks++;
				assert (busy === 1'b1) else begin
					$display("extra start pulse could not be placed while busy_o was high");
					errors++;
				end
				start = 1'b1;
			end
			@(negedge Clock);
			seen = done;
			n++;
		end
		start = 1'b0;
		if (!seen) begin
			$display("done_o did not arrive within %0d cycles of start", run_limit);
			errors++;
		end
		// a restarted run would show up as more writes or a second done
		repeat (50) @(negedge Clock);
		checks++;
		assert (done_count - dones0 == 1 && write_count - writes0 == n_blocks * 32
			&& busy === 1'b0)
		else begin
			$display("[ERROR] %0t: run gave %0d done pulses, %0d writes, busy_o=%b",
				$time, done_count - dones0, write_count - writes0, busy);
			errors++;
		end
	endtask

	task automatic compare_frame();
		int i;
		logic [15:0] got;
		for (i = 0; i < pixel_words; i++) begin
			got = sram[pixel_base + i];
			checks++;
			assert (got === exp_pix[i]) else begin
				$display("[ERROR] %0t: pixel word %h is %h, expected %h",
					$time, pixel_base + i, got, exp_pix[i]);
				errors++;
			end
		end
	endtask

	// uniform bytes per block from the DC term or saturated bytes for kind 3
	task automatic check_block_values(input int kind);
		int br, bc, r, p, a, dc, v;
		logic [7:0] pix;
		logic [15:0] want, got;
		for (br = 0; br < block_rows; br++)
			for (bc = 0; bc < blocks_per_row; bc++) begin
				a = pixel_base + br * blk_n * pix_pitch + bc * 4;
				dc = coef[br * blk_n * frame_w + bc * blk_n];
				if (kind == 3) begin
					want = ((br * blocks_per_row + bc) % 2 == 0) ? 16'hffff : 16'h0000;
				end else begin
					// a lone DC term is scaled by table entry 0 in each pass
					v = (dc * int'(cos_table[0])) >>> 8;
					v = (v * int'(cos_table[0])) >>> 16;
					pix = clip_byte(v);
					want = {pix, pix};
				end
				for (r = 0; r < blk_n; r++)
					for (p = 0; p < 4; p++) begin
						got = sram[a + r * pix_pitch + p];
						checks++;
						assert (got === want) else begin
							$display("[ERROR] %0t: block (%0d,%0d) word %h is %h, expected %h",
								$time, br, bc, a + r * pix_pitch + p, got, want);
							errors++;
						end
					end
			end
	endtask

	task automatic check_idle();
		repeat (64) begin
			@(negedge Clock);
			checks++;
			assert (sram_req.we_n === 1'b1 && busy === 1'b0 && done === 1'b0) else begin
				$display("[ERROR] %0t: idle outputs we_n=%b busy_o=%b done_o=%b",
					$time, sram_req.we_n, busy, done);
				errors++;
			end
		end
	endtask

	task automatic end_test(input string name);
		test_num++;
		if (fault_total() == faults_at_start) begin
			$display("test %0d %s: ok", test_num, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: failed", test_num, name);
		end
		faults_at_start = fault_total();
	endtask

	initial begin : main
		int a;
		Resetn = 1'b0;
		start = 1'b0;
		for (a = 0; a < sram_words; a++)
			sram[a] = fill_word(a);
		repeat (3) @(posedge Clock);
		@(negedge Clock);
		Resetn = 1'b1;

		check_idle();
		end_test("idle after reset");

		make_frame(0);
		load_frame();
		run_frame(1'b0);
		compare_frame();
		end_test("zero frame");

		make_frame(1);
		load_frame();
		run_frame(1'b0);
		compare_frame();
		check_block_values(1);
		end_test("DC-only blocks");

		make_frame(2);
		load_frame();
		run_frame(1'b0);
		compare_frame();
		end_test("small random coefficients");

		make_frame(3);
		load_frame();
		run_frame(1'b0);
		compare_frame();
		check_block_values(3);
		end_test("clipping of large DC");

		make_frame(2);
		load_frame();
		run_frame(1'b1);
		compare_frame();
		end_test("start while busy");

		$display("tests %0d, failed %0d, checks %0d, errors %0d, property failures %0d",
			test_num, failed_tests, checks, errors, i_dut.u_props.fail_count);
		if (fault_total() == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
src/idct_pkg.sv
src/block_fetch.sv
src/idct_pass.sv
src/pixel_writer.sv
src/idct_top.sv
verif/tb_clock.sv
verif/idct_props.sv
verif/idct_tb.sv

//--- Makefile
# Verilator flow for the block IDCT testbench
# override from the command line, e.g. make sim SEED=7 LOG=run.log

VERILATOR ?= verilator
TOP       ?= idct_tb
SEED      ?= 1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --timing --assert
RUN_ARGS  ?= +verilator+seed+$(SEED) +verilator+error+limit+1000

SOURCES := $(wildcard src/*.sv verif/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
